// ==== hdl/csi2_pkg.sv ====
package csi2_pkg;

  localparam int WORD_W     = 32;
  localparam int HDR_DATA_W = 24;
  localparam int ECC_W      = 6;
  localparam int ECC_LSB    = 24;
  localparam int WC_WORDS_W = 14;

  localparam logic [5:0] DT_SHORT_MAX = 6'h0F; // types 0x00..0x0F are short packets.

  typedef enum logic [5:0] {
    DT_FRAME_START = 6'h00,
    DT_FRAME_END   = 6'h01,
    DT_RAW10       = 6'h2B
  } csi2_dt_e;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } csi2_word_t;

  typedef struct packed {
    logic [1:0]  zero;
    logic [5:0]  ecc;
    logic [15:0] word_count; // payload length in bytes.
    logic [1:0]  vc;
    logic [5:0]  data_type;
  } csi2_hdr_t;

  typedef struct packed {
    logic              valid;
    logic              last;
    logic [WORD_W-1:0] data;
  } payload_word_t;

  // one mask per parity bit, P0 first.
  localparam logic [HDR_DATA_W-1:0] ECC_MASKS [ECC_W] = '{
    24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00
  };

  function automatic logic [ECC_W-1:0] ecc_calc(input logic [HDR_DATA_W-1:0] d);
    logic [ECC_W-1:0] p;
    for (int j = 0; j < ECC_W; j++)
    begin
      p[j] = ^(d & ECC_MASKS[j]);
    end
    return p;
  endfunction

  function automatic logic [ECC_W-1:0] ecc_col(input int idx);
    logic [ECC_W-1:0] c;
    for (int j = 0; j < ECC_W; j++)
    begin
      c[j] = ECC_MASKS[j][idx];
    end
    return c;
  endfunction

endpackage

// ==== hdl/video_pkg.sv ====
package video_pkg;

  localparam int PIX_W         = 10;
  localparam int PIX_PER_GROUP = 4;
  localparam int GROUP_BYTES   = PIX_PER_GROUP + 1;
  localparam int GROUP_W       = 8 * GROUP_BYTES;
  localparam int ACC_W         = 64;
  localparam int FILL_W        = $clog2(ACC_W / 8 + 1);
  localparam int CREDIT_MAX    = 8;
  localparam int CREDIT_W      = $clog2(CREDIT_MAX + 1);
  localparam int OUT_BUF_DEPTH = 16;
  localparam int OUT_BUF_AW    = $clog2(OUT_BUF_DEPTH);

  typedef logic [PIX_W-1:0] pixel_t;

  typedef struct packed {
    pixel_t [PIX_PER_GROUP-1:0] pix;
    logic                       line_end;
  } pix_group_t;

  typedef struct packed {
    pix_group_t group;
    logic       frame_start;
    logic       valid;
  } px_beat_t;

endpackage

// ==== hdl/csi2_header_ecc.sv ====
module csi2_header_ecc import csi2_pkg::*; (
  input  logic       rx_clk,
  input  logic       rst_n_i,
  input  csi2_word_t word_i,
  input  logic       pkt_done_i,
  output csi2_word_t word_o,
  output logic       error_o,
  output logic       corrected_o
);

  logic              hdr_exp;
  logic              is_hdr;
  csi2_hdr_t         hdr;
  logic [ECC_W-1:0]  syndrome;
  logic [WORD_W-1:0] flip;
  logic              single;

  assign hdr      = csi2_hdr_t'(word_i.data);
  assign is_hdr   = word_i.valid && hdr_exp;
  assign syndrome = ecc_calc(word_i.data[HDR_DATA_W-1:0]) ^ hdr.ecc;

  // a syndrome equal to one column points at the single flipped bit.
  always_comb
  begin
    flip = '0;
    for (int i = 0; i < HDR_DATA_W; i++)
    begin
      if (syndrome == ecc_col(i))
        flip[i] = 1'b1;
    end
    for (int j = 0; j < ECC_W; j++)
    begin
      if (syndrome == ECC_W'(1 << j))
        flip[ECC_LSB + j] = 1'b1; // error in the ECC field itself.
    end
  end

  assign single = |flip;

  always_ff @(posedge rx_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hdr_exp <= 1'b1;
    end
    else if (word_i.valid)
    begin
      hdr_exp <= 1'b0;
    end
    else if (pkt_done_i)
    begin
      hdr_exp <= 1'b1; // next valid word starts a new packet.
    end
  end

  always_ff @(posedge rx_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      word_o      <= '0;
      error_o     <= 1'b0;
      corrected_o <= 1'b0;
    end
    else
    begin
      word_o.valid <= word_i.valid;
      word_o.data  <= is_hdr ? (word_i.data ^ flip) : word_i.data;
      corrected_o  <= is_hdr && single;
      error_o      <= is_hdr && (syndrome != '0) && !single;
    end
  end

endmodule

// ==== hdl/csi2_pkt_parser.sv ====
module csi2_pkt_parser import csi2_pkg::*; (
  input  logic          rx_clk,
  input  logic          rst_n_i,
  input  csi2_word_t    word_i,
  input  logic          hdr_error_i,
  output payload_word_t payload_o,
  output logic          frame_start_o,
  output logic          frame_end_o,
  output logic          pkt_done_o
);

  typedef enum logic [1:0] {
    HEADER,
    PAYLOAD,
    FOOTER,
    DONE
  } state_e;

  state_e                state;
  csi2_hdr_t             hdr;
  logic [WC_WORDS_W-1:0] remaining;
  logic                  raw;

  assign hdr = csi2_hdr_t'(word_i.data);

  always_ff @(posedge rx_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state         <= HEADER;
      remaining     <= '0;
      raw           <= 1'b0;
      payload_o     <= '0;
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      pkt_done_o    <= 1'b0;
    end
    else
    begin
      payload_o.valid <= 1'b0;
      payload_o.last  <= 1'b0;
      payload_o.data  <= word_i.data;
      frame_start_o   <= 1'b0;
      frame_end_o     <= 1'b0;
      pkt_done_o      <= 1'b0;
      case (state)
        HEADER:
        begin
          if (word_i.valid)
          begin
            if (hdr_error_i)
            begin
              pkt_done_o <= 1'b1; // header cannot be trusted, drop the packet.
            end
            else if (hdr.data_type <= DT_SHORT_MAX)
            begin
              frame_start_o <= (hdr.data_type == DT_FRAME_START);
              frame_end_o   <= (hdr.data_type == DT_FRAME_END);
              state         <= DONE;
            end
            else
            begin
              raw       <= (hdr.data_type == DT_RAW10); // other types are counted, not sent.
              remaining <= hdr.word_count[15:2];
              state     <= (hdr.word_count[15:2] == '0) ? FOOTER : PAYLOAD;
            end
          end
        end
        PAYLOAD:
        begin
          if (word_i.valid)
          begin
            payload_o.valid <= raw;
            payload_o.last  <= (remaining == WC_WORDS_W'(1));
            remaining       <= remaining - 1'b1;
            if (remaining == WC_WORDS_W'(1))
              state <= FOOTER;
          end
        end
        FOOTER:
        begin
          if (word_i.valid)
            state <= DONE; // crc word is discarded.
        end
        default:
        begin
          pkt_done_o <= 1'b1;
          state      <= HEADER;
        end
      endcase
    end
  end

endmodule

// ==== hdl/raw10_gearbox.sv ====
module raw10_gearbox import csi2_pkg::*, video_pkg::*; (
  input  logic          rx_clk,
  input  logic          rst_n_i,
  input  payload_word_t payload_i,
  output pix_group_t    group_o,
  output logic          group_valid_o
);

  logic [ACC_W-1:0]  acc;
  logic [ACC_W-1:0]  comb;
  logic [FILL_W-1:0] fill;
  logic [FILL_W-1:0] comb_fill;
  logic              emit;
  pix_group_t        group_d;

  // new bytes land just above the ones already held.
  always_comb
  begin
    comb      = acc;
    comb_fill = fill;
    if (payload_i.valid)
    begin
      comb      = acc | ({{(ACC_W - WORD_W){1'b0}}, payload_i.data} << {fill, 3'b000});
      comb_fill = fill + FILL_W'(WORD_W / 8);
    end
  end

  assign emit = (comb_fill >= FILL_W'(GROUP_BYTES));

  always_comb
  begin
    for (int k = 0; k < PIX_PER_GROUP; k++)
    begin
      group_d.pix[k] = {comb[8 * k +: 8], comb[8 * PIX_PER_GROUP + 2 * k +: 2]};
    end
    group_d.line_end = payload_i.valid && payload_i.last; // lines are whole groups.
  end

  always_ff @(posedge rx_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      acc           <= '0;
      fill          <= '0;
      group_valid_o <= 1'b0;
    end
    else
    begin
      group_valid_o <= emit;
      if (emit)
      begin
        acc  <= comb >> GROUP_W;
        fill <= comb_fill - FILL_W'(GROUP_BYTES);
      end
      else
      begin
        acc  <= comb;
        fill <= comb_fill;
      end
    end
  end

  always_ff @(posedge rx_clk)
  begin
    if (emit)
      group_o <= group_d;
  end

endmodule

// ==== hdl/px_credit_out.sv ====
module px_credit_out import video_pkg::*; (
  input  logic       rx_clk,
  input  logic       rst_n_i,
  input  pix_group_t group_i,
  input  logic       group_valid_i,
  input  logic       frame_start_i,
  input  logic       credit_i,
  output px_beat_t   px_o,
  output logic       overflow_o
);

  pix_group_t          mem_grp [OUT_BUF_DEPTH];
  logic                mem_fs  [OUT_BUF_DEPTH];
  logic [OUT_BUF_AW:0] wr_ptr;
  logic [OUT_BUF_AW:0] rd_ptr;
  logic                fs_pend;
  logic [CREDIT_W-1:0] credits;
  logic                empty;
  logic                full;
  logic                wr_en;
  logic                rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[OUT_BUF_AW] != rd_ptr[OUT_BUF_AW]) &&
                 (wr_ptr[OUT_BUF_AW-1:0] == rd_ptr[OUT_BUF_AW-1:0]);
  assign wr_en = group_valid_i && !full;
  assign rd_en = !empty && (credits != '0);

  always_ff @(posedge rx_clk)
  begin
    if (wr_en)
    begin
      mem_grp[wr_ptr[OUT_BUF_AW-1:0]] <= group_i;
      mem_fs[wr_ptr[OUT_BUF_AW-1:0]]  <= fs_pend || frame_start_i;
    end
  end

  always_ff @(posedge rx_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fs_pend    <= 1'b0;
      credits    <= CREDIT_W'(CREDIT_MAX);
      overflow_o <= 1'b0;
      px_o       <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en)
        fs_pend <= 1'b0; // the mark went out with this group.
      else if (frame_start_i)
        fs_pend <= 1'b1;
      credits <= credits - CREDIT_W'(rd_en) + CREDIT_W'(credit_i);
      if (group_valid_i && full)
        overflow_o <= 1'b1; // group dropped, stays set until reset.
      px_o.valid       <= rd_en;
      px_o.group       <= mem_grp[rd_ptr[OUT_BUF_AW-1:0]];
      px_o.frame_start <= mem_fs[rd_ptr[OUT_BUF_AW-1:0]];
    end
  end

endmodule

// ==== hdl/csi2_rx_core.sv ====
module csi2_rx_core import csi2_pkg::*, video_pkg::*; (
  input  logic       rx_clk,
  input  logic       rst_n_i,
  input  csi2_word_t rx_word_i,
  input  logic       credit_i,
  output logic       phy_rst_o,
  output px_beat_t   px_o,
  output logic       frame_end_o,
  output logic       hdr_error_o,
  output logic       hdr_corrected_o,
  output logic       overflow_o
);

  csi2_word_t    ecc_word;
  payload_word_t payload;
  logic          frame_start;
  pix_group_t    group;
  logic          group_valid;

  csi2_header_ecc header_ecc (
    .rx_clk      ( rx_clk          ),
    .rst_n_i     ( rst_n_i         ),
    .word_i      ( rx_word_i       ),
    .pkt_done_i  ( phy_rst_o       ),
    .word_o      ( ecc_word        ),
    .error_o     ( hdr_error_o     ),
    .corrected_o ( hdr_corrected_o )
  );

  csi2_pkt_parser pkt_parser (
    .rx_clk        ( rx_clk      ),
    .rst_n_i       ( rst_n_i     ),
    .word_i        ( ecc_word    ),
    .hdr_error_i   ( hdr_error_o ),
    .payload_o     ( payload     ),
    .frame_start_o ( frame_start ),
    .frame_end_o   ( frame_end_o ),
    .pkt_done_o    ( phy_rst_o   )
  );

  raw10_gearbox gearbox (
    .rx_clk        ( rx_clk      ),
    .rst_n_i       ( rst_n_i     ),
    .payload_i     ( payload     ),
    .group_o       ( group       ),
    .group_valid_o ( group_valid )
  );

  px_credit_out credit_out (
    .rx_clk        ( rx_clk      ),
    .rst_n_i       ( rst_n_i     ),
    .group_i       ( group       ),
    .group_valid_i ( group_valid ),
    .frame_start_i ( frame_start ),
    .credit_i      ( credit_i    ),
    .px_o          ( px_o        ),
    .overflow_o    ( overflow_o  )
  );

endmodule

// ==== verif/tb_csi2_rx.sv ====
module tb_csi2_rx import csi2_pkg::*, video_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic       rx_clk;
  logic       rst_n_i;
  csi2_word_t rx_word_i;
  logic       credit_i;
  logic       phy_rst_o;
  px_beat_t   px_o;
  logic       frame_end_o;
  logic       hdr_error_o;
  logic       hdr_corrected_o;
  logic       overflow_o;

  int       seed;
  int       credit_seed;
  int       errors;
  int       checks;
  int       tests;
  int       mark;
  int       outstanding; // beats received but not yet credited back.
  int       credit_mode; // 0 withheld, 1 every cycle, 2 random.
  int       n_phy_rst;
  int       n_frame_end;
  int       n_hdr_err;
  int       n_hdr_fix;
  int       base_rst;
  int       base_err;
  int       base_fix;
  int       base_fe;
  logic     fs_mark;
  logic     give_credit;
  px_beat_t exp_q [$];

  csi2_rx_core uut (
    .rx_clk          ( rx_clk          ),
    .rst_n_i         ( rst_n_i         ),
    .rx_word_i       ( rx_word_i       ),
    .credit_i        ( credit_i        ),
    .phy_rst_o       ( phy_rst_o       ),
    .px_o            ( px_o            ),
    .frame_end_o     ( frame_end_o     ),
    .hdr_error_o     ( hdr_error_o     ),
    .hdr_corrected_o ( hdr_corrected_o ),
    .overflow_o      ( overflow_o      )
  );

  initial rx_clk = 1'b0;
  always #50 rx_clk = ~rx_clk;

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string why);
    errors++;
    $display("%s", why);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - mark);
    mark = errors;
  endtask

  // each data bit toggles the parity bits whose mask selects it.
  function automatic logic [5:0] parity_of(input logic [23:0] d);
    logic [5:0] p;
    p = '0;
    for (int i = 0; i < 24; i++)
    begin
      for (int j = 0; j < 6; j++)
      begin
        if (d[i] && ECC_MASKS[j][i])
          p[j] = ~p[j];
      end
    end
    return p;
  endfunction

  function automatic logic [31:0] make_header(input logic [5:0] dt, input logic [15:0] wc);
    logic [23:0] d;
    d = {wc, 2'b00, dt};
    return {2'b00, parity_of(d), d};
  endfunction

  task automatic drive_word(input logic [31:0] d);
    @(negedge rx_clk);
    rx_word_i.valid = 1'b1;
    rx_word_i.data  = d;
  endtask

  task automatic end_packet();
    int n;
    @(negedge rx_clk);
    rx_word_i.valid = 1'b0;
    rx_word_i.data  = '0;
    n = 0;
    while (!phy_rst_o && n < 200)
    begin
      @(negedge rx_clk);
      n++;
    end
    if (!phy_rst_o)
      report_timeout("timeout: no phy_rst_o pulse within 200 cycles after a packet");
    @(negedge rx_clk); // the header stage rearms on the pulse edge.
  endtask

  task automatic wait_drained(input bit all_credits);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || (all_credits && outstanding != 0)) && n < 2000)
    begin
      @(posedge rx_clk);
      n++;
    end
    if (exp_q.size() != 0 || (all_credits && outstanding != 0))
      report_timeout("timeout: expected pixel beats did not arrive within 2000 cycles");
  endtask

  task automatic send_short(input logic [5:0] dt);
    drive_word(make_header(dt, 16'($random(seed))));
    end_packet();
    if (dt == DT_FRAME_START)
      fs_mark = 1'b1;
  endtask

  // flips is the number of header bit errors and keep the number of groups the buffer holds.
  task automatic send_line(input int blocks, input int flips, input int keep);
    logic [7:0]  b [];
    logic [31:0] hdr;
    px_beat_t    beat;
    int          nbytes;
    int          bit_a;
    int          bit_b;
    nbytes = 20 * blocks;
    b = new[nbytes];
    foreach (b[i])
    begin
      b[i] = 8'($random(seed));
    end
    hdr   = make_header(DT_RAW10, 16'(nbytes));
    bit_a = {$random(seed)} % 30;
    bit_b = (bit_a + 1 + {$random(seed)} % 29) % 30;
    if (flips >= 1)
      hdr[bit_a] = ~hdr[bit_a];
    if (flips == 2)
    begin
      hdr[bit_b] = ~hdr[bit_b];
      drive_word(hdr); // the link drops after a header it cannot trust.
      end_packet();
      return;
    end
    for (int g = 0; g < nbytes / 5 && g < keep; g++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        beat.group.pix[k] = {b[5 * g + k], b[5 * g + 4][2 * k +: 2]};
      end
      beat.group.line_end = (g == nbytes / 5 - 1);
      beat.frame_start    = fs_mark;
      beat.valid          = 1'b1;
      fs_mark             = 1'b0;
      exp_q.push_back(beat);
    end
    drive_word(hdr);
    for (int w = 0; w < nbytes / 4; w++)
    begin
      drive_word({b[4 * w + 3], b[4 * w + 2], b[4 * w + 1], b[4 * w]});
    end
    drive_word($random(seed)); // crc footer.
    end_packet();
  endtask

  // the pixel sink counts pulses, compares beats and returns credits.
  always @(negedge rx_clk)
  begin
    if (rst_n_i)
    begin
      n_phy_rst   += int'(phy_rst_o);
      n_frame_end += int'(frame_end_o);
      n_hdr_err   += int'(hdr_error_o);
      n_hdr_fix   += int'(hdr_corrected_o);
      if (px_o.valid)
      begin
        outstanding++;
        check_value("outstanding > CREDIT_MAX", outstanding > CREDIT_MAX, 0);
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("a pixel beat arrived while none was expected: %h", px_o);
        end
        else
          check_value("px_o", px_o, exp_q.pop_front());
      end
      give_credit = 1'b0;
      if (outstanding > 0)
      begin
        if (credit_mode == 1)
          give_credit = 1'b1;
        else if (credit_mode == 2)
          give_credit = ({$random(credit_seed)} % 100) < 30;
      end
      credit_i = give_credit;
      if (give_credit)
        outstanding--;
    end
  end

  initial
  begin
    seed        = 32'h60458b81;
    credit_seed = 32'h60458b81;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    mark        = 0;
    outstanding = 0;
    credit_mode = 1;
    n_phy_rst   = 0;
    n_frame_end = 0;
    n_hdr_err   = 0;
    n_hdr_fix   = 0;
    fs_mark     = 1'b0;
    rst_n_i     = 1'b0;
    rx_word_i   = '0;
    credit_i    = 1'b0;
    repeat (5) @(negedge rx_clk);
    rst_n_i = 1'b1;

    check_value("px_o.valid", px_o.valid, 0);
    check_value("phy_rst_o", phy_rst_o, 0);
    check_value("frame_end_o", frame_end_o, 0);
    check_value("hdr_error_o", hdr_error_o, 0);
    check_value("hdr_corrected_o", hdr_corrected_o, 0);
    check_value("overflow_o", overflow_o, 0);
    finish_test("idle after reset");

    base_fe = n_frame_end;
    send_short(DT_FRAME_START);
    repeat (20) send_line(1 + {$random(seed)} % 6, 0, 24);
    send_short(DT_FRAME_END);
    wait_drained(1);
    check_value("frame_end_o pulses", n_frame_end - base_fe, 1);
    finish_test("pixel data");

    base_fix = n_hdr_fix;
    base_err = n_hdr_err;
    send_line(1 + {$random(seed)} % 4, 1, 24);
    wait_drained(1);
    check_value("hdr_corrected_o pulses", n_hdr_fix - base_fix, 1);
    check_value("hdr_error_o pulses", n_hdr_err - base_err, 0);
    finish_test("single-bit header error");

    base_err = n_hdr_err;
    base_rst = n_phy_rst;
    send_line(1 + {$random(seed)} % 4, 2, 24);
    send_line(1 + {$random(seed)} % 4, 0, 24); // a stray beat would land before this line.
    wait_drained(1);
    check_value("hdr_error_o pulses", n_hdr_err - base_err, 1);
    check_value("phy_rst_o pulses", n_phy_rst - base_rst, 2);
    finish_test("double-bit header error");

    credit_mode = 2;
    repeat (12)
    begin
      send_line(1 + {$random(seed)} % 4, 0, 24);
      wait_drained(0);
    end
    credit_mode = 1;
    wait_drained(1);
    check_value("overflow_o", overflow_o, 0);
    finish_test("random credits");

    credit_mode = 0;
    send_line(2, 0, 24); // uses up all eight credits.
    wait_drained(0);
    send_line(6, 0, OUT_BUF_DEPTH);
    check_value("overflow_o", overflow_o, 1);
    credit_mode = 1;
    wait_drained(1);
    check_value("overflow_o", overflow_o, 1);
    finish_test("buffer overflow");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/csi2_pkg.sv
hdl/video_pkg.sv
hdl/csi2_header_ecc.sv
hdl/csi2_pkt_parser.sv
hdl/raw10_gearbox.sv
hdl/px_credit_out.sv
hdl/csi2_rx_core.sv
verif/tb_csi2_rx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; passes only if the pass line appears in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_csi2_rx \
  --Mdir obj_dir -o tb_csi2_rx \
  && ./obj_dir/tb_csi2_rx | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "simulation run succeeded" \
  || { echo "simulation run did not succeed"; exit 1; }
